// ==== logic/data_ram.sv ====
// 64-bit word RAM with per-byte write enables and a registered read port
`default_nettype none

module data_ram #(
    parameter int addr_width = 10
) (
    input  logic                                clk,
    input  mem_pkg::ram_wr_t                    wr,
    input  logic                                wen,
    input  logic                                ren,
    input  logic [mem_pkg::max_addr_width-1:0]  rindex,
    output logic [mem_pkg::xlen-1:0]            rword
);

    localparam int depth = 2 ** addr_width;

    // contents are not reset
    logic [mem_pkg::xlen-1:0] mem [depth];

    logic [addr_width-1:0] widx;
    logic [addr_width-1:0] ridx;

    // only the low index bits address this RAM size
    assign widx = wr.index[addr_width-1:0];
    assign ridx = rindex[addr_width-1:0];

    // write lane by lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < mem_pkg::lanes; i++) begin
            if (wen && wr.be[i]) begin
                mem[widx][i*8 +: 8] <= wr.data[i*8 +: 8];
            end
        end
    end

    // read word registered on ren, holds otherwise
    always_ff @(posedge clk) begin
        if (ren) begin
            rword <= mem[ridx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
// load lane selection with zero or sign extension of the registered RAM word
`default_nettype none

module load_align (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      ren,
    input  mem_pkg::mem_op_e          op,
    input  logic [2:0]                byte_off,
    input  logic [mem_pkg::xlen-1:0]  rword,
    output logic [mem_pkg::xlen-1:0]  rdata
);

    mem_pkg::mem_op_e          op_q;
    logic [2:0]                off_q;
    logic [mem_pkg::xlen-1:0]  shifted;

    // opcode and byte offset ride along with the RAM read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q  <= mem_pkg::ld;
            off_q <= 3'd0;
        end else if (ren) begin
            op_q  <= op;
            off_q <= byte_off;
        end
    end

    // wanted bytes down to lane 0
    assign shifted = rword >> {off_q, 3'b000};

    // keep the access width, then extend
    always_comb begin
        case (op_q)
            mem_pkg::lb: begin
                rdata = {{56{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::lh: begin
                rdata = {{48{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::lw: begin
                rdata = {{32{shifted[31]}}, shifted[31:0]};
            end
            mem_pkg::lbu: begin
                rdata = {56'd0, shifted[7:0]};
            end
            mem_pkg::lhu: begin
                rdata = {48'd0, shifted[15:0]};
            end
            mem_pkg::lwu: begin
                rdata = {32'd0, shifted[31:0]};
            end
            // ld, whole word
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/lsu_mem.sv ====
// data memory top: window and alignment check, strobe gating, RAM and lane paths, response pulses
`default_nettype none

module lsu_mem #(
    parameter int addr_width = 10
) (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::mem_rsp_t rsp
);

    // window length in bytes, 8 bytes per word
    localparam logic [mem_pkg::xlen-1:0] win_len = 64'd8 << addr_width;

    logic [mem_pkg::xlen-1:0] offset;
    logic [3:0]               size;
    logic [2:0]               align_mask;
    logic                     in_window;
    logic                     aligned;
    logic                     legal;
    logic                     ram_wen;
    logic                     ram_ren;
    logic                     rvalid_q;
    logic                     fault_q;
    mem_pkg::ram_wr_t         wr;
    logic [mem_pkg::xlen-1:0] rword;
    logic [mem_pkg::xlen-1:0] ld_data;

    // byte offset into the window
    assign offset = req.addr - mem_pkg::ram_base;

    // below base wraps the offset high, so test both bounds
    assign in_window = (req.addr >= mem_pkg::ram_base) && (offset < win_len);

    // low address bits must be zero for the access size
    assign size       = mem_pkg::access_bytes(req.op);
    assign align_mask = 3'(size - 4'd1);
    assign aligned    = (req.addr[2:0] & align_mask) == 3'b000;

    assign legal   = in_window && aligned;
    assign ram_wen = req.wen && legal;
    assign ram_ren = req.ren && legal;

    // one-cycle result pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            rvalid_q <= ram_ren;
            fault_q  <= (req.ren || req.wen) && !legal;
        end
    end

    store_align u_store_align (
        .op     (req.op),
        .offset (offset),
        .wdata  (req.wdata),
        .wr     (wr)
    );

    data_ram #(
        .addr_width (addr_width)
    ) u_data_ram (
        .clk    (clk),
        .wr     (wr),
        .wen    (ram_wen),
        .ren    (ram_ren),
        .rindex (offset[3 +: mem_pkg::max_addr_width]),
        .rword  (rword)
    );

    // byte offset of the window equals the low address bits
    load_align u_load_align (
        .clk      (clk),
        .arst_n   (arst_n),
        .ren      (ram_ren),
        .op       (req.op),
        .byte_off (offset[2:0]),
        .rword    (rword),
        .rdata    (ld_data)
    );

    assign rsp.rdata  = ld_data;
    assign rsp.rvalid = rvalid_q;
    assign rsp.fault  = fault_q;

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
// load/store opcodes, request, response and RAM write structs, RAM window constants, size helper
`default_nettype none

package mem_pkg;

    // data and address width of the core
    localparam int xlen = 64;

    // byte lanes per RAM word
    localparam int lanes = xlen / 8;

    // word index field is sized for the largest RAM that fits it
    localparam int max_addr_width = 16;

    // first byte address of the data RAM window
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_8000_0000;

    // load opcodes; stores reuse lb/lh/lw/ld as their width
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } mem_op_e;

    // one load or store from the core
    typedef struct packed {
        mem_op_e         op;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            ren;
        logic            wen;
    } mem_req_t;

    // load data plus the one-cycle result pulses
    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            rvalid;
        logic            fault;
    } mem_rsp_t;

    // lane-steered write into the word RAM
    typedef struct packed {
        logic [max_addr_width-1:0] index;
        logic [lanes-1:0]          be;
        logic [xlen-1:0]           data;
    } ram_wr_t;

    // access size in bytes
    function automatic logic [3:0] access_bytes(input mem_op_e op);
        logic [3:0] size;
        case (op)
            lb, lbu: size = 4'd1;
            lh, lhu: size = 4'd2;
            lw, lwu: size = 4'd4;
            default: size = 4'd8;
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire

// ==== logic/store_align.sv ====
// store lane steering: byte-enable mask, replicated write data and word index
`default_nettype none

module store_align (
    input  mem_pkg::mem_op_e          op,
    input  logic [mem_pkg::xlen-1:0]  offset,
    input  logic [mem_pkg::xlen-1:0]  wdata,
    output mem_pkg::ram_wr_t          wr
);

    logic [3:0]               size;
    logic [mem_pkg::lanes-1:0] base_mask;
    logic [mem_pkg::xlen-1:0] rep_data;

    assign size = mem_pkg::access_bytes(op);

    // mask for a lane-0 access of this size
    // and data copied into every lane
    always_comb begin
        case (size)
            4'd1: begin
                base_mask = 8'h01;
                rep_data  = {8{wdata[7:0]}};
            end
            4'd2: begin
                base_mask = 8'h03;
                rep_data  = {4{wdata[15:0]}};
            end
            4'd4: begin
                base_mask = 8'h0f;
                rep_data  = {2{wdata[31:0]}};
            end
            default: begin
                base_mask = 8'hff;
                rep_data  = wdata;
            end
        endcase
    end

    // aligned by the top level, so the shift never spills out
    assign wr.be    = base_mask << offset[2:0];
    assign wr.data  = rep_data;
    // word index from the bits above the byte offset
    assign wr.index = offset[3 +: mem_pkg::max_addr_width];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module lsu_mem_tb -o lsu_mem_sim || exit 1
out="$(./obj_dir/lsu_mem_sim 2>&1)"
echo "$out"
grep -q "Finished with no errors" <<< "$out" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
logic/mem_pkg.sv
logic/store_align.sv
logic/data_ram.sv
logic/load_align.sv
logic/lsu_mem.sv
testbench/lsu_mem_chk.sv
testbench/lsu_mem_tb.sv

// ==== testbench/lsu_mem_chk.sv ====
// concurrent assertions on lsu_mem strobes and result pulses, own legality decode, with its bind
`default_nettype none

module lsu_mem_chk #(
    parameter int addr_width = 10
) (
    input logic              clk,
    input logic              arst_n,
    input mem_pkg::mem_req_t req,
    input mem_pkg::mem_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    // first byte past the RAM window
    localparam logic [mem_pkg::xlen-1:0] win_end = mem_pkg::ram_base + (64'd8 << addr_width);

    logic [2:0] low_mask;
    logic       legal_ren;

    // address bits that must be zero for the access width
    always_comb begin
        case (req.op)
            mem_pkg::lb, mem_pkg::lbu: low_mask = 3'b000;
            mem_pkg::lh, mem_pkg::lhu: low_mask = 3'b001;
            mem_pkg::lw, mem_pkg::lwu: low_mask = 3'b011;
            default: low_mask = 3'b111;
        endcase
    end

    // read strobe inside the window and naturally aligned
    assign legal_ren = req.ren
                       && (req.addr >= mem_pkg::ram_base)
                       && (req.addr < win_end)
                       && ((req.addr[2:0] & low_mask) == 3'b000);

    // single request address, one strobe at a time
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(req.ren && req.wen))
        else $error("ren and wen high in the same cycle");

    // a result is either data or a fault
    a_one_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        !(rsp.rvalid && rsp.fault))
        else $error("rvalid and fault high in the same cycle");

    // legal read shows up exactly one cycle later
    a_rvalid_after_ren: assert property (@(posedge clk) disable iff (!arst_n)
        legal_ren |=> rsp.rvalid)
        else $error("rvalid missing one cycle after a legal ren");

    a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
        !legal_ren |=> !rsp.rvalid)
        else $error("rvalid without a legal ren the cycle before");

    // pulses quiet while reset is held
    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!rsp.rvalid && !rsp.fault))
        else $error("rvalid or fault high during reset");

endmodule

bind lsu_mem lsu_mem_chk #(
    .addr_width (addr_width)
) u_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
);

`default_nettype wire

// ==== testbench/lsu_mem_tb.sv ====
// lsu_mem testbench: clock, reset, lfsr stimulus, byte-array reference model, response checks
`default_nettype none

module lsu_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int addr_width = 10;
    localparam logic [63:0] win_end = mem_pkg::ram_base + (64'd8 << addr_width);
    localparam int region = 64;
    localparam int timeout = 20;

    logic              clk;
    logic              arst_n;
    mem_pkg::mem_req_t req;
    mem_pkg::mem_rsp_t rsp;
    logic [15:0]       lfsr;
    // byte model of the first 64 bytes of the window
    logic [7:0]        model [region];
    logic              written [region];
    // expected response to the request driven last cycle
    logic              pend_valid;
    logic              pend_fault;
    logic              pend_known;
    logic [63:0]       pend_data;

    lsu_mem #(.addr_width(addr_width)) u_dut (.clk, .arst_n, .req, .rsp);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int op_size(input mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::lb, mem_pkg::lbu: return 1;
            mem_pkg::lh, mem_pkg::lhu: return 2;
            mem_pkg::lw, mem_pkg::lwu: return 4;
            default: return 8;
        endcase
    endfunction

    // little-endian gather, then sign fill for lb lh lw
    function automatic logic [63:0] model_load(input mem_pkg::mem_op_e op, input int off);
        logic [63:0] v;
        int          n;
        n = op_size(op);
        v = '0;
        for (int i = n - 1; i >= 0; i--) begin
            v = {v[55:0], model[off + i]};
        end
        if (n < 8 && op inside {mem_pkg::lb, mem_pkg::lh, mem_pkg::lw} && v[8*n-1]) begin
            v = v | (~64'd0 << (8 * n));
        end
        return v;
    endfunction

    function automatic mem_pkg::mem_req_t make_req(input mem_pkg::mem_op_e op,
        input logic [63:0] addr, input logic [63:0] wdata, input logic ren, input logic wen);
        mem_pkg::mem_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.ren   = ren;
        r.wen   = wen;
        return r;
    endfunction

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pending();
        check_val("rsp.rvalid", 64'(rsp.rvalid), 64'(pend_valid));
        check_val("rsp.fault", 64'(rsp.fault), 64'(pend_fault));
        if (pend_valid && pend_known) begin
            check_val("rsp.rdata", rsp.rdata, pend_data);
        end
    endtask

    // legality by window and natural alignment, stores go into the model
    task automatic expect_req(input mem_pkg::mem_req_t r);
        int   n;
        int   off;
        logic legal;
        n     = op_size(r.op);
        legal = r.addr >= mem_pkg::ram_base && r.addr < win_end
                && (r.addr % 64'(n)) == 64'd0;
        pend_valid = r.ren && legal;
        pend_fault = (r.ren || r.wen) && !legal;
        pend_known = 1'b1;
        if (legal) begin
            off = int'(r.addr - mem_pkg::ram_base);
            for (int i = 0; i < n; i++) begin
                if (r.wen) begin
                    model[off + i]   = r.wdata[8*i +: 8];
                    written[off + i] = 1'b1;
                end
                pend_known = pend_known && written[off + i];
            end
            pend_data = model_load(r.op, off);
        end
    endtask

    // check last cycle's response, then drive the next request
    task automatic drive_cycle(input mem_pkg::mem_req_t r);
        @(posedge clk);
        #1;
        check_pending();
        expect_req(r);
        req = r;
    endtask

    // one access, then idle until rvalid or fault shows up
    task automatic access_wait(input mem_pkg::mem_req_t r);
        int   cycles;
        logic seen;
        drive_cycle(r);
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #1;
            cycles++;
            req  = make_req(mem_pkg::ld, '0, '0, 1'b0, 1'b0);
            seen = rsp.rvalid || rsp.fault;
            if (!seen && cycles >= timeout) begin
                $display("timeout: no rvalid or fault within %0d cycles of the request", timeout);
                fail_run();
            end
        end
        check_val("load latency", 64'(cycles), 64'd1);
        check_pending();
        pend_valid = 1'b0;
        pend_fault = 1'b0;
    endtask

    initial begin
        mem_pkg::mem_op_e op;
        logic [63:0]      addr;
        int               n;
        lfsr       = 16'd47359;
        req        = make_req(mem_pkg::ld, '0, '0, 1'b0, 1'b0);
        arst_n     = 1'b0;
        pend_valid = 1'b0;
        pend_fault = 1'b0;
        pend_known = 1'b0;
        pend_data  = '0;
        for (int i = 0; i < region; i++) begin
            model[i]   = '0;
            written[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;

        // fill the region with doubles, read them back
        for (int w = 0; w < 8; w++) begin
            drive_cycle(make_req(mem_pkg::ld, mem_pkg::ram_base + 64'(8 * w), rand_bits(64), 0, 1));
        end
        for (int w = 0; w < 8; w++) begin
            access_wait(make_req(mem_pkg::ld, mem_pkg::ram_base + 64'(8 * w), '0, 1, 0));
        end

        // narrow stores, each followed by ld of its word
        for (int k = 0; k < 24; k++) begin
            op   = mem_pkg::mem_op_e'(3'(int'(rand_bits(2)) % 3));
            n    = op_size(op);
            addr = mem_pkg::ram_base + (rand_bits(6) & ~64'(n - 1));
            drive_cycle(make_req(op, addr, rand_bits(64), 0, 1));
            access_wait(make_req(mem_pkg::ld, addr & ~64'd7, '0, 1, 0));
        end

        // narrow loads, signed and unsigned
        for (int k = 0; k < 32; k++) begin
            n    = int'(rand_bits(3)) % 6;
            op   = mem_pkg::mem_op_e'(3'(n < 3 ? n : n + 1));
            addr = mem_pkg::ram_base + (rand_bits(6) & ~64'(op_size(op) - 1));
            access_wait(make_req(op, addr, '0, 1, 0));
        end

        // below base and past the window end
        for (int k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
                addr = mem_pkg::ram_base - 64'(8 * (1 + int'(rand_bits(4))));
            end else begin
                addr = win_end + 64'(8 * int'(rand_bits(4)));
            end
            access_wait(make_req(mem_pkg::ld, addr, rand_bits(64), k >= 4, k < 4));
        end

        // misaligned half, word and double, both directions
        for (int k = 0; k < 12; k++) begin
            n    = int'(rand_bits(3)) % 5;
            op   = mem_pkg::mem_op_e'(3'(n < 3 ? n + 1 : n + 2));
            n    = op_size(op);
            addr = mem_pkg::ram_base + (rand_bits(6) & ~64'(n - 1));
            addr = addr + 64'(1 + int'(rand_bits(3)) % (n - 1));
            access_wait(make_req(op, addr, rand_bits(64), k % 2 == 0, k % 2 == 1));
        end

        // faulted stores must have left the region alone
        for (int w = 0; w < 8; w++) begin
            access_wait(make_req(mem_pkg::ld, mem_pkg::ram_base + 64'(8 * w), '0, 1, 0));
        end

        // one load per cycle, checked in order
        for (int k = 0; k < 16; k++) begin
            op   = mem_pkg::mem_op_e'(3'(int'(rand_bits(3)) % 7));
            addr = mem_pkg::ram_base + (rand_bits(6) & ~64'(op_size(op) - 1));
            drive_cycle(make_req(op, addr, '0, 1, 0));
        end
        drive_cycle(make_req(mem_pkg::ld, '0, '0, 0, 0));
        drive_cycle(make_req(mem_pkg::ld, '0, '0, 0, 0));

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
